/* src/zx_config.svh */
//////////////////////////////////////////////////////////////////////
// memory paging core configuration
// port addresses, window count and bus widths
//////////////////////////////////////////////////////////////////////

`ifndef ZX_CONFIG_SVH
`define ZX_CONFIG_SVH

// 16 KB address windows in the Z80 space
`define ZX_WINDOWS      4

// page numbers and mapped address widths
`define ZX_PAGE_W       8
`define ZX_ROMPG_W      5
`define ZX_RAMADDR_W    22

// 128K paging port, full decode
`define ZX_PORT_7FFD    16'h7FFD

// pager enable and window pager ports, low byte
`define ZX_PORT_77      8'h77
`define ZX_PORT_F7      8'hF7

// address bits 13..8 of the window pager port
`define ZX_F7_MID       6'h3F

// opcode fetch from this high byte enters DOS
`define ZX_DOS_TRAP_HI  8'h3D

`endif

/* src/zx_pkg.sv */
//////////////////////////////////////////////////////////////////////
// memory paging core types
//////////////////////////////////////////////////////////////////////

`include "zx_config.svh"

package zx_pkg;

	typedef logic [15:0]                      zaddr_t;
	typedef logic [7:0]                       zdata_t;
	typedef logic [`ZX_PAGE_W-1:0]            page_t;
	typedef logic [`ZX_ROMPG_W-1:0]           rompg_t;
	typedef logic [`ZX_RAMADDR_W-1:0]         ramaddr_t;
	typedef logic [$clog2(`ZX_WINDOWS)-1:0]   win_t;

	// z80 bus, strobes are one fclk cycle wide
	typedef struct packed {
		zaddr_t a;
		zdata_t d;
		logic   io_wr;
		logic   mem_req;
		logic   m1;
	} zbus_t;

	// one window mapping, romnram set means ROM
	typedef struct packed {
		logic  romnram;
		page_t page;
	} win_map_t;

	// 7FFD register contents
	typedef struct packed {
		logic [2:0] bank;
		logic       rom_sel;
		logic       lock;
	} pent_cfg_t;

	// window pager port write
	typedef struct packed {
		logic   stb;
		win_t   win;
		zdata_t data;
	} atm_wr_t;

	// decoded memory cycle
	typedef struct packed {
		logic     csrom;
		rompg_t   rom_page;
		ramaddr_t ram_addr;
	} mem_sel_t;

	typedef enum logic {
		DOS_OFF,
		DOS_ON
	} dos_state_t;

endpackage

/* src/zports.sv */
//////////////////////////////////////////////////////////////////////
// z80 port writes: 7FFD paging register with lock, pager enable
// bit and window pager port forwarding
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "zx_config.svh"

module zports
(
	input  logic              fclk,
	input  logic              reset,

	input  zx_pkg::zbus_t     bus,

	output zx_pkg::pent_cfg_t pent_cfg,
	output logic              pager_on,
	output zx_pkg::atm_wr_t   atm_wr
);

	import zx_pkg::*;

	logic      hit_7ffd;
	logic      hit_77;
	logic      hit_f7;
	pent_cfg_t cfg_d;
	win_t      f7_win;

	//////////////////////////////////////////////////////////////////////
	// address decode
	//////////////////////////////////////////////////////////////////////

	// full 16-bit match for the 128K port
	assign hit_7ffd = bus.io_wr && (bus.a == `ZX_PORT_7FFD);

	assign hit_77 = bus.io_wr && (bus.a[7:0] == `ZX_PORT_77);

	// pager port also needs the middle address bits set,
	// the top two pick the window
	assign hit_f7 = bus.io_wr && (bus.a[7:0] == `ZX_PORT_F7) &&
		(bus.a[13:8] == `ZX_F7_MID);

	assign f7_win = bus.a[15:14];

	//////////////////////////////////////////////////////////////////////
	// 7FFD and 77 registers
	//////////////////////////////////////////////////////////////////////

	// bank in bits 2:0, rom select in bit 4, lock in bit 5
	always_comb
	begin
		cfg_d.bank    = bus.d[2:0];
		cfg_d.rom_sel = bus.d[4];
		cfg_d.lock    = bus.d[5];
	end

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			pent_cfg <= '0;
			pager_on <= 1'b0;
		end
		else
		begin
			// once locked, only reset reopens the port
			if (hit_7ffd && !pent_cfg.lock)
				pent_cfg <= cfg_d;

			if (hit_77)
				pager_on <= bus.d[0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// window pager write strobe
	//////////////////////////////////////////////////////////////////////

	// io_wr is a single cycle, so the strobe is too
	always_comb
	begin
		atm_wr.stb  = hit_f7;
		atm_wr.win  = f7_win;
		atm_wr.data = bus.d;
	end

endmodule

/* src/atm_pager.sv */
//////////////////////////////////////////////////////////////////////
// one 16 KB window pager: page register, fixed 128K fallback and
// DOS entry/exit detection on opcode fetches
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "zx_config.svh"

module atm_pager
#(
	parameter int WINDOW = 0
)
(
	input  logic               fclk,
	input  logic               reset,

	input  zx_pkg::zbus_t      bus,
	input  zx_pkg::pent_cfg_t  pent_cfg,
	input  logic               pager_on,
	input  logic               dos,
	input  zx_pkg::atm_wr_t    atm_wr,

	output zx_pkg::win_map_t   win_map,
	output logic               dos_turn_on,
	output logic               dos_turn_off
);

	import zx_pkg::*;

	win_map_t map_reg;
	win_map_t fixed_map;
	logic     in_window;

	//////////////////////////////////////////////////////////////////////
	// page register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
			map_reg <= '0;
		else if (atm_wr.stb && (atm_wr.win == win_t'(WINDOW)))
		begin
			// bit 7 selects ROM, page in 5..0
			map_reg.romnram <= atm_wr.data[7];
			map_reg.page    <= page_t'(atm_wr.data[5:0]);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// 128K layout when the pager is off
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		fixed_map = '0;
		case (WINDOW)
			0:
			begin
				// basic ROM pair, DOS clears bit 1
				fixed_map.romnram = 1'b1;
				fixed_map.page    = page_t'({~dos, pent_cfg.rom_sel});
			end
			1:
				fixed_map.page = page_t'(5);
			2:
				fixed_map.page = page_t'(2);
			default:
				fixed_map.page = page_t'(pent_cfg.bank);
		endcase
	end

	assign win_map = pager_on ? map_reg : fixed_map;

	//////////////////////////////////////////////////////////////////////
	// DOS turn requests
	//////////////////////////////////////////////////////////////////////

	// opcode fetch landing in this window
	assign in_window = bus.mem_req && bus.m1 && (bus.a[15:14] == win_t'(WINDOW));

	// enter from the basic ROM at 3Dxx
	assign dos_turn_on = in_window && win_map.romnram && win_map.page[0] &&
		(bus.a[15:8] == `ZX_DOS_TRAP_HI);

	// any fetch from RAM leaves DOS
	assign dos_turn_off = in_window && !win_map.romnram;

endmodule

/* src/zdos.sv */
//////////////////////////////////////////////////////////////////////
// DOS ROM switch, set and cleared by the window pagers
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "zx_config.svh"

module zdos
(
	input  logic                   fclk,
	input  logic                   reset,

	input  logic [`ZX_WINDOWS-1:0] turn_on,
	input  logic [`ZX_WINDOWS-1:0] turn_off,

	output logic                   dos
);

	import zx_pkg::*;

	dos_state_t state;
	dos_state_t state_nx;

	always_comb
	begin
		state_nx = state;
		case (state)
			DOS_OFF:
				if (|turn_on)
					state_nx = DOS_ON;
			DOS_ON:
				if (|turn_off)
					state_nx = DOS_OFF;
			default:
				state_nx = DOS_OFF;
		endcase
	end

	always_ff @(posedge fclk)
	begin
		if (reset)
			state <= DOS_OFF;
		else
			state <= state_nx;
	end

	assign dos = (state == DOS_ON);

endmodule

/* src/zmem.sv */
//////////////////////////////////////////////////////////////////////
// memory decoder: picks the addressed window and registers the
// ROM page or RAM byte address with a valid strobe
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "zx_config.svh"

module zmem
(
	input  logic                                fclk,
	input  logic                                reset,

	input  zx_pkg::zbus_t                       bus,
	input  zx_pkg::win_map_t [`ZX_WINDOWS-1:0]  win_maps,

	output logic                                map_valid,
	output zx_pkg::mem_sel_t                    map_out
);

	import zx_pkg::*;

	win_t     win_idx;
	win_map_t cur_map;
	mem_sel_t sel_d;

	//////////////////////////////////////////////////////////////////////
	// window select and address forming
	//////////////////////////////////////////////////////////////////////

	assign win_idx = bus.a[15:14];
	assign cur_map = win_maps[win_idx];

	always_comb
	begin
		if (cur_map.romnram)
		begin
			sel_d.csrom    = 1'b1;
			sel_d.rom_page = cur_map.page[`ZX_ROMPG_W-1:0];
			sel_d.ram_addr = '0;
		end
		else
		begin
			// page on top of the 14-bit window offset
			sel_d.csrom    = 1'b0;
			sel_d.rom_page = '0;
			sel_d.ram_addr = {cur_map.page, bus.a[13:0]};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////////////////////////

	// one result per request, back-to-back allowed
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			map_valid <= 1'b0;
			map_out   <= '0;
		end
		else
		begin
			map_valid <= bus.mem_req;
			if (bus.mem_req)
				map_out <= sel_d;
		end
	end

endmodule

/* src/zx_memmap_top.sv */
//////////////////////////////////////////////////////////////////////
// Z80 memory paging core top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "zx_config.svh"

module zx_memmap_top
(
	input  logic             fclk,
	input  logic             reset,

	input  zx_pkg::zbus_t    bus,

	output logic             map_valid,
	output zx_pkg::mem_sel_t map_out,
	output logic             dos
);

	import zx_pkg::*;

	pent_cfg_t                    pent_cfg;
	logic                         pager_on;
	atm_wr_t                      atm_wr;
	win_map_t [`ZX_WINDOWS-1:0]   win_maps;
	logic [`ZX_WINDOWS-1:0]       dos_turn_on;
	logic [`ZX_WINDOWS-1:0]       dos_turn_off;

	zports zports_i
	(
		.fclk    (fclk    ),
		.reset   (reset   ),
		.bus     (bus     ),
		.pent_cfg(pent_cfg),
		.pager_on(pager_on),
		.atm_wr  (atm_wr  )
	);

	// one pager per window
	for (genvar i = 0; i < `ZX_WINDOWS; i++)
	begin : gen_pager
		atm_pager #(.WINDOW(i)) pager_i
		(
			.fclk        (fclk           ),
			.reset       (reset          ),
			.bus         (bus            ),
			.pent_cfg    (pent_cfg       ),
			.pager_on    (pager_on       ),
			.dos         (dos            ),
			.atm_wr      (atm_wr         ),
			.win_map     (win_maps[i]    ),
			.dos_turn_on (dos_turn_on[i] ),
			.dos_turn_off(dos_turn_off[i])
		);
	end

	zdos zdos_i
	(
		.fclk    (fclk        ),
		.reset   (reset       ),
		.turn_on (dos_turn_on ),
		.turn_off(dos_turn_off),
		.dos     (dos         )
	);

	zmem zmem_i
	(
		.fclk     (fclk     ),
		.reset    (reset    ),
		.bus      (bus      ),
		.win_maps (win_maps ),
		.map_valid(map_valid),
		.map_out  (map_out  )
	);

endmodule

/* verif/zx_memmap_assertions.sv */
//////////////////////////////////////////////////////////////////////
// bound checks on the paging core outputs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module zx_memmap_assertions
(
	input logic             fclk,
	input logic             reset,
	input zx_pkg::zbus_t    bus,
	input logic             map_valid,
	input zx_pkg::mem_sel_t map_out
);

	import zx_pkg::*;

	// one result strobe per request, one cycle later
	property p_valid_follows_req;
		@(posedge fclk) disable iff (reset)
			bus.mem_req |=> map_valid;
	endproperty

	property p_no_valid_without_req;
		@(posedge fclk) disable iff (reset)
			!bus.mem_req |=> !map_valid;
	endproperty

	// ROM cycles carry no RAM address
	property p_rom_has_no_ram_addr;
		@(posedge fclk) disable iff (reset)
			!(map_out.csrom && (map_out.ram_addr != '0));
	endproperty

	property p_quiet_after_reset;
		@(posedge fclk) reset |=> !map_valid;
	endproperty

	a_valid_follows_req: assert property (p_valid_follows_req)
		else $error("map_valid missing one cycle after mem_req");
	a_no_valid_without_req: assert property (p_no_valid_without_req)
		else $error("map_valid raised without a mem_req");
	a_rom_has_no_ram_addr: assert property (p_rom_has_no_ram_addr)
		else $error("csrom set together with a nonzero ram_addr");
	a_quiet_after_reset: assert property (p_quiet_after_reset)
		else $error("map_valid high right after reset");

endmodule

/* verif/tb_zx_memmap.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the memory paging core
// directed and random port writes and memory cycles against a model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "zx_config.svh"

module tb_zx_memmap;

	import zx_pkg::*;

	typedef struct packed {
		mem_sel_t    sel;
		logic        dos;
		logic [31:0] cyc;
	} expect_t;

	logic     fclk;
	logic     reset;
	zbus_t    bus;
	logic     map_valid;
	mem_sel_t map_out;
	logic     dos;

	// model state
	pent_cfg_t m_cfg;
	logic      m_pager_on;
	win_map_t  m_win [`ZX_WINDOWS];
	logic      m_dos;

	expect_t   exp_q [$];
	int        n_ops;
	int        cycles;
	int        seed;

	zx_memmap_top dut_i
	(
		.fclk     (fclk     ),
		.reset    (reset    ),
		.bus      (bus      ),
		.map_valid(map_valid),
		.map_out  (map_out  ),
		.dos      (dos      )
	);

	bind zx_memmap_top zx_memmap_assertions assertions_i
	(
		.fclk     (fclk     ),
		.reset    (reset    ),
		.bus      (bus      ),
		.map_valid(map_valid),
		.map_out  (map_out  )
	);

	initial fclk = 1'b0;
	always #5 fclk = ~fclk;

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	// window map seen by the CPU from the pager register or the 128K layout
	function automatic win_map_t model_map(input win_t w);
		win_map_t m;
		m = '0;
		if (m_pager_on)
			m = m_win[w];
		else if (w == 2'd0)
		begin
			m.romnram = 1'b1;
			m.page    = {6'd0, ~m_dos, m_cfg.rom_sel};
		end
		else if (w == 2'd1)
			m.page = 8'd5;
		else if (w == 2'd2)
			m.page = 8'd2;
		else
			m.page = {5'd0, m_cfg.bank};
		return m;
	endfunction

	function automatic mem_sel_t ref_sel(input zaddr_t a);
		win_map_t m;
		mem_sel_t s;
		m = model_map(a[15:14]);
		s = '0;
		if (m.romnram)
		begin
			s.csrom    = 1'b1;
			s.rom_page = m.page[4:0];
		end
		else
			s.ram_addr = {m.page, a[13:0]};
		return s;
	endfunction

	task automatic model_reset();
		m_cfg      = '0;
		m_pager_on = 1'b0;
		m_dos      = 1'b0;
		for (int i = 0; i < `ZX_WINDOWS; i++)
			m_win[i] = '0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// error reporting
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("*** FAILED ***");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("** Error: %s expected 0x%h got 0x%h", name, exp, got);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus tasks driven on the falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic idle();
		@(negedge fclk);
		bus = '0;
	endtask

	task automatic port_write(input zaddr_t a, input zdata_t d);
		@(negedge fclk);
		bus       = '0;
		bus.a     = a;
		bus.d     = d;
		bus.io_wr = 1'b1;
		n_ops++;
		if ((a == `ZX_PORT_7FFD) && !m_cfg.lock)
		begin
			m_cfg.bank    = d[2:0];
			m_cfg.rom_sel = d[4];
			m_cfg.lock    = d[5];
		end
		if (a[7:0] == `ZX_PORT_77)
			m_pager_on = d[0];
		if ((a[7:0] == `ZX_PORT_F7) && (a[13:8] == `ZX_F7_MID))
		begin
			m_win[a[15:14]].romnram = d[7];
			m_win[a[15:14]].page    = {2'b00, d[5:0]};
		end
	endtask

	task automatic mem_read(input zaddr_t a, input logic m1);
		expect_t  e;
		win_map_t m;
		@(negedge fclk);
		bus         = '0;
		bus.a       = a;
		bus.mem_req = 1'b1;
		bus.m1      = m1;
		n_ops++;
		// result uses the DOS state before this fetch
		e.sel = ref_sel(a);
		e.cyc = 32'(cycles);
		m = model_map(a[15:14]);
		if (m1 && !m_dos && m.romnram && m.page[0] && (a[15:8] == `ZX_DOS_TRAP_HI))
			m_dos = 1'b1;
		else if (m1 && m_dos && !m.romnram)
			m_dos = 1'b0;
		e.dos = m_dos;
		exp_q.push_back(e);
	endtask

	task automatic apply_reset();
		idle();
		@(negedge fclk);
		reset = 1'b1;
		model_reset();
		repeat (5) @(negedge fclk);
		reset = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// compare and timeout
	//////////////////////////////////////////////////////////////////////

	always @(negedge fclk)
	begin
		expect_t e;
		if (!reset && map_valid)
		begin
			assert (exp_q.size() != 0)
			else
			begin
				$display("map_valid was raised with no memory request outstanding");
				abort_run();
			end
			e = exp_q.pop_front();
			check_value("result cycle", 32'(cycles), e.cyc + 32'd1);
			check_value("map_out.csrom", 32'(map_out.csrom), 32'(e.sel.csrom));
			check_value("map_out.rom_page", 32'(map_out.rom_page), 32'(e.sel.rom_page));
			check_value("map_out.ram_addr", 32'(map_out.ram_addr), 32'(e.sel.ram_addr));
			check_value("dos", 32'(dos), 32'(e.dos));
		end
	end

	always @(posedge fclk)
	begin
		cycles = cycles + 1;
		if (cycles > 2 * n_ops + 100)
		begin
			$display("timeout after %0d cycles, results still missing", cycles);
			abort_run();
		end
	end

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0] r;
		bus       = '0;
		reset     = 1'b1;
		n_ops     = 0;
		cycles    = 0;
		seed      = 32'h97a7_dd6a;
		model_reset();
		repeat (5) @(negedge fclk);
		reset = 1'b0;

		// layout straight after reset
		mem_read(16'h0123, 1'b0);
		mem_read(16'h4567, 1'b0);
		mem_read(16'h8abc, 1'b0);
		mem_read(16'hC000, 1'b0);

		// 7FFD bank and rom_sel before and after the lock
		port_write(16'h7FFD, 8'h03);
		mem_read(16'hC010, 1'b0);
		port_write(16'h7FFD, 8'h16);
		mem_read(16'h0010, 1'b0);
		mem_read(16'hFFFF, 1'b0);
		port_write(16'h7FFD, 8'h31);
		port_write(16'h7FFD, 8'h07);
		mem_read(16'hC100, 1'b0);
		mem_read(16'h0100, 1'b0);

		// DOS entry and exit with plain reads in between
		mem_read(16'h3D2F, 1'b0);
		mem_read(16'h3D2F, 1'b1);
		mem_read(16'h0000, 1'b0);
		mem_read(16'h3D00, 1'b1);
		mem_read(16'h8000, 1'b0);
		mem_read(16'h4000, 1'b1);
		mem_read(16'h0000, 1'b0);

		// reset reopens the locked port
		apply_reset();
		port_write(16'h7FFD, 8'h05);
		mem_read(16'hC123, 1'b0);

		// window pager remapping one window at a time
		port_write(16'h0077, 8'h01);
		port_write(16'h3FF7, 8'h85);
		port_write(16'h7FF7, 8'h21);
		port_write(16'hBFF7, 8'h3E);
		port_write(16'hFFF7, 8'h9F);
		port_write(16'h12F7, 8'h11);
		mem_read(16'h0042, 1'b0);
		mem_read(16'h5555, 1'b0);
		mem_read(16'hAAAA, 1'b0);
		mem_read(16'hF00F, 1'b0);
		mem_read(16'h3D10, 1'b1);
		mem_read(16'h4001, 1'b1);
		port_write(16'h0077, 8'h00);
		mem_read(16'h0042, 1'b0);
		mem_read(16'hF00F, 1'b0);

		// random mix with back-to-back memory cycles
		for (int i = 0; i < 300; i++)
		begin
			r = $random(seed);
			case (r[2:0])
				3'd0:
					port_write(`ZX_PORT_7FFD, r[15:8] & 8'hDF);
				3'd1:
					port_write({r[31:24], `ZX_PORT_77}, r[15:8]);
				3'd2:
					port_write({r[31:30], `ZX_F7_MID, `ZX_PORT_F7}, r[15:8]);
				3'd3:
					mem_read({`ZX_DOS_TRAP_HI, r[23:16]}, r[24]);
				default:
					mem_read(r[31:16], r[3]);
			endcase
		end

		idle();
		while (exp_q.size() != 0)
			@(negedge fclk);
		repeat (2) idle();

		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* src.f */
+incdir+src
src/zx_pkg.sv
src/zports.sv
src/atm_pager.sv
src/zdos.sv
src/zmem.sv
src/zx_memmap_top.sv
verif/zx_memmap_assertions.sv
verif/tb_zx_memmap.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module tb_zx_memmap -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
